// File: Bender.yml
package:
  name: riscv_sp

sources:
  - include_dirs:
      - src
    files:
      - src/riscv_sp_pkg.sv
      - src/icache.sv
      - src/ifq.sv
      - src/sync_fifo.sv
      - src/dispatcher.sv
      - src/riscv_sp_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/riscv_sp_tb.sv

// File: riscv_sp_top.f
+incdir+src
src/riscv_sp_pkg.sv
src/icache.sv
src/ifq.sv
src/sync_fifo.sv
src/dispatcher.sv
src/riscv_sp_top.sv
verif/riscv_sp_tb.sv

// File: src/dispatcher.sv
// instruction decode, register file, scoreboard and integer execution fifo
`include "riscv_sp_config.svh"

module dispatcher (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         inst_valid,
	input  riscv_sp_pkg::inst_t          inst,
	input  riscv_sp_pkg::addr_t          inst_pc,
	output logic                         inst_pop,
	input  logic                         cdb_valid,
	input  riscv_sp_pkg::cdb_t           cdb,
	input  logic                         int_rd,
	output logic                         int_fifo_empty,
	output riscv_sp_pkg::int_fifo_data_t int_fifo_data
);
	import riscv_sp_pkg::*;

	opcode_t        opcode;
	logic [2:0]     func3;
	logic [6:0]     func7;
	reg_idx_t       rd;
	reg_idx_t       rs1;
	reg_idx_t       rs2;
	data_t          imm;
	logic           is_r;
	logic           is_i;
	logic           supported;
	logic           hazard;
	logic           issue;
	logic           fifo_full;
	int_fifo_data_t entry;

	data_t          regs [32];
	// one busy bit per register, x0 stays clear
	logic [31:0]    busy;

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign func3  = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign func7  = inst[31:25];
	assign imm    = {{20{inst[31]}}, inst[31:20]};

	assign is_r = (opcode == R_TYPE);
	assign is_i = (opcode == I_TYPE);

	always_comb begin
		supported = 1'b0;
		if (is_r) begin
			// add and sub share func3
			if (func3 == F3_ADD) begin
				supported = (func7 == F7_BASE) || (func7 == F7_SUB);
			end else if (func3 == F3_XOR || func3 == F3_OR || func3 == F3_AND) begin
				supported = (func7 == F7_BASE);
			end
		end else if (is_i) begin
			supported = (func3 == F3_ADD) || (func3 == F3_XOR) ||
				(func3 == F3_OR) || (func3 == F3_AND);
		end
	end

	// rs2 field is immediate bits for i-type
	assign hazard = busy[rs1] || (is_r && busy[rs2]) || busy[rd];

	assign issue    = inst_valid && supported && !hazard && !fifo_full;
	// unsupported words are dropped in the same cycle
	assign inst_pop = issue || (inst_valid && !supported);

	always_comb begin
		entry.pc                   = inst_pc;
		entry.opcode               = opcode;
		entry.func3                = func3;
		entry.func7                = func7;
		entry.rd                   = rd;
		entry.common_data.rs1_data = regs[rs1];
		entry.common_data.rs2_data = is_i ? imm : regs[rs2];
	end

	// no bypass, cdb data is read from the next cycle on
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (cdb_valid && cdb.tag != '0) begin
				regs[cdb.tag] <= cdb.data;
				busy[cdb.tag] <= 1'b0;
			end
			if (issue && rd != '0) begin
				busy[rd] <= 1'b1;
			end
		end
	end

	sync_fifo #(
		.WIDTH($bits(int_fifo_data_t)),
		.DEPTH(`INT_FIFO_DEPTH)
	) int_exec_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.push     (issue),
		.push_data(entry),
		.pop      (int_rd),
		.pop_data (int_fifo_data),
		.empty    (int_fifo_empty),
		.full     (fifo_full)
	);

endmodule

// File: src/icache.sv
// instruction cache line array with fill port and one-cycle registered read
`include "riscv_sp_config.svh"

module icache (
	input  logic                    clk,
	input  logic                    fill_en,
	input  riscv_sp_pkg::line_idx_t fill_index,
	input  riscv_sp_pkg::line_t     fill_line,
	input  logic                    rd_en,
	input  riscv_sp_pkg::line_idx_t rd_index,
	output riscv_sp_pkg::line_t     rd_line
);
	import riscv_sp_pkg::*;

	line_t cache_memory [`ICACHE_LINES];

	// fill port, used while the core is held in reset
	always_ff @(posedge clk) begin
		if (fill_en) begin
			cache_memory[fill_index] <= fill_line;
		end
	end

	// line valid the cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_line <= cache_memory[rd_index];
		end
	end

endmodule

// File: src/ifq.sv
// fetch sequencer and four-entry instruction fetch queue with redirect flush
`include "riscv_sp_config.svh"

module ifq (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    jmp_branch_valid,
	input  riscv_sp_pkg::addr_t     jmp_branch_address,
	output logic                    rd_en,
	output riscv_sp_pkg::line_idx_t rd_index,
	input  riscv_sp_pkg::line_t     rd_line,
	input  logic                    inst_pop,
	output logic                    inst_valid,
	output riscv_sp_pkg::inst_t     inst,
	output riscv_sp_pkg::addr_t     inst_pc
);
	import riscv_sp_pkg::*;

	localparam int IDX_W = $bits(line_idx_t);

	fetch_state_t state;
	addr_t        pc;
	addr_t        next_line_pc;
	line_t        line_q;
	logic [27:0]  line_tag;
	// read position in the held line, 4 means empty
	logic [2:0]   head;
	logic         line_load;

	// start of the following line, wraps at the cache end
	always_comb begin
		next_line_pc = pc;
		next_line_pc[3:0] = 4'h0;
		next_line_pc[4 +: IDX_W] = pc[4 +: IDX_W] + 1'b1;
	end

	// response arrives the cycle after the request went out
	assign line_load = (state == wait_line) && !rd_en && !jmp_branch_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= idle;
			pc       <= `RESET_PC;
			head     <= 3'd4;
			rd_en    <= 1'b0;
			rd_index <= '0;
		end else if (jmp_branch_valid) begin
			// flush queue, any line in flight is ignored
			state <= idle;
			pc    <= jmp_branch_address;
			head  <= 3'd4;
			rd_en <= 1'b0;
		end else begin
			case (state)
				idle: begin
					// queue is always empty here
					rd_en    <= 1'b1;
					rd_index <= pc[4 +: IDX_W];
					state    <= wait_line;
				end
				wait_line: begin
					if (rd_en) begin
						rd_en <= 1'b0;
					end else begin
						// skip words before the pc offset
						head  <= {1'b0, pc[3:2]};
						pc    <= next_line_pc;
						state <= drain;
					end
				end
				drain: begin
					if (inst_pop) begin
						head <= head + 3'd1;
						if (head == 3'd3) begin
							state <= idle;
						end
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (line_load) begin
			line_q   <= rd_line;
			line_tag <= pc[31:4];
		end
	end

	assign inst_valid = ~head[2];
	assign inst       = line_q[{head[1:0], 5'd0} +: 32];
	assign inst_pc    = {line_tag, head[1:0], 2'b00};

endmodule

// File: src/riscv_sp_config.svh
// cache size, integer fifo depth and reset vector macros
`ifndef RISCV_SP_CONFIG_SVH
`define RISCV_SP_CONFIG_SVH

// number of 128-bit lines in the instruction cache
`define ICACHE_LINES 8

// entries in the integer execution fifo
`define INT_FIFO_DEPTH 4

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: src/riscv_sp_pkg.sv
// shared vector types, opcode and func constants, fetch states and bus structs
`include "riscv_sp_config.svh"

package riscv_sp_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [31:0] inst_t;
	// word 0 of the line sits in bits 31:0
	typedef logic [127:0] line_t;
	typedef logic [$clog2(`ICACHE_LINES)-1:0] line_idx_t;
	// register number, doubles as the cdb tag
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	localparam opcode_t R_TYPE = 7'b0110011;
	localparam opcode_t I_TYPE = 7'b0010011;

	// func encodings of the supported alu operations
	localparam logic [2:0] F3_ADD = 3'h0;
	localparam logic [2:0] F3_XOR = 3'h4;
	localparam logic [2:0] F3_OR  = 3'h6;
	localparam logic [2:0] F3_AND = 3'h7;
	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_SUB  = 7'h20;

	typedef enum logic [1:0] {
		idle,
		wait_line,
		drain
	} fetch_state_t;

	typedef struct packed {
		data_t rs1_data;
		// sign-extended immediate for i-type
		data_t rs2_data;
	} common_data_t;

	typedef struct packed {
		addr_t        pc;
		opcode_t      opcode;
		logic [2:0]   func3;
		logic [6:0]   func7;
		reg_idx_t     rd;
		common_data_t common_data;
	} int_fifo_data_t;

	typedef struct packed {
		reg_idx_t tag;
		data_t    data;
	} cdb_t;

endpackage

// File: src/riscv_sp_top.sv
// front end top: instruction cache, fetch queue and dispatcher
module riscv_sp_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         fill_en,
	input  riscv_sp_pkg::line_idx_t      fill_index,
	input  riscv_sp_pkg::line_t          fill_line,
	input  logic                         jmp_branch_valid,
	input  riscv_sp_pkg::addr_t          jmp_branch_address,
	input  logic                         cdb_valid,
	input  riscv_sp_pkg::cdb_t           cdb,
	input  logic                         int_rd,
	output logic                         int_fifo_empty,
	output riscv_sp_pkg::int_fifo_data_t int_fifo_data
);
	import riscv_sp_pkg::*;

	logic      rd_en;
	line_idx_t rd_index;
	line_t     rd_line;
	logic      inst_valid;
	logic      inst_pop;
	inst_t     inst;
	addr_t     inst_pc;

	icache cache (
		.clk       (clk),
		.fill_en   (fill_en),
		.fill_index(fill_index),
		.fill_line (fill_line),
		.rd_en     (rd_en),
		.rd_index  (rd_index),
		.rd_line   (rd_line)
	);

	ifq fetch_queue (
		.clk               (clk),
		.arst_n            (arst_n),
		.jmp_branch_valid  (jmp_branch_valid),
		.jmp_branch_address(jmp_branch_address),
		.rd_en             (rd_en),
		.rd_index          (rd_index),
		.rd_line           (rd_line),
		.inst_pop          (inst_pop),
		.inst_valid        (inst_valid),
		.inst              (inst),
		.inst_pc           (inst_pc)
	);

	dispatcher dispatcher (
		.clk           (clk),
		.arst_n        (arst_n),
		.inst_valid    (inst_valid),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_pop      (inst_pop),
		.cdb_valid     (cdb_valid),
		.cdb           (cdb),
		.int_rd        (int_rd),
		.int_fifo_empty(int_fifo_empty),
		.int_fifo_data (int_fifo_data)
	);

endmodule

// File: src/sync_fifo.sv
// parameterized first-word-fall-through fifo with count-based flags
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             empty,
	output logic             full
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// head entry shows without a read cycle
	assign pop_data = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == (AW + 1)'(DEPTH));

endmodule

// File: verif/riscv_sp_tb.sv
// testbench: program load, integer unit model, reference register file and checks
`include "riscv_sp_config.svh"

module riscv_sp_tb;
	import riscv_sp_pkg::*;

	logic           clk = 1'b0;
	logic           arst_n;
	logic           fill_en;
	line_idx_t      fill_index;
	line_t          fill_line;
	logic           jmp_branch_valid;
	addr_t          jmp_branch_address;
	logic           cdb_valid;
	cdb_t           cdb;
	logic           int_rd;
	logic           int_fifo_empty;
	int_fifo_data_t int_fifo_data;

	inst_t       prog [32];
	data_t       model_regs [32];
	// issued to the integer unit, result not yet on cdb
	logic [31:0] pending;
	cdb_t        result_q [$];
	logic [4:0]  exp_idx;
	addr_t       redirect_target;
	logic        redirect_pending;
	int          old_pops;
	logic        pop_enable;
	int          pop_count;
	int          fifo_level;

	riscv_sp_top dut (.*);

	always #10 clk = ~clk;

	task automatic stop_with(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		stop_with($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, expected));
	endtask

	function automatic inst_t r_word(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, R_TYPE};
	endfunction

	function automatic inst_t i_word(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd);
		return {imm, rs1, f3, rd, I_TYPE};
	endfunction

	function automatic bit is_supported(input inst_t w);
		if (w[6:0] == R_TYPE) begin
			return (w[14:12] == 3'h0 && (w[31:25] == 7'h00 || w[31:25] == 7'h20)) ||
				(w[14:12] inside {3'h4, 3'h6, 3'h7} && w[31:25] == 7'h00);
		end
		return w[6:0] == I_TYPE && w[14:12] inside {3'h0, 3'h4, 3'h6, 3'h7};
	endfunction

	function automatic data_t alu_result(input inst_t w, input data_t a, input data_t b);
		case (w[14:12])
			3'h0: return (w[6:0] == R_TYPE && w[30]) ? a - b : a + b;
			3'h4: return a ^ b;
			3'h6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// index of the first alu word at or after start, wrapping at the cache end
	function automatic logic [4:0] next_supported(input logic [4:0] start);
		logic [4:0] i;
		i = start;
		for (int n = 0; n < 32; n++) begin
			if (is_supported(prog[i])) begin
				return i;
			end
			i = i + 5'd1;
		end
		return i;
	endfunction

	task automatic build_program();
		for (int i = 0; i < 32; i++) begin
			prog[i] = '0;
		end
		prog[0]  = i_word(12'd5, 5'd0, 3'h0, 5'd1);
		prog[1]  = i_word(12'hffd, 5'd0, 3'h0, 5'd2);
		// independent words, enough to fill the integer fifo
		prog[2]  = i_word(12'h055, 5'd0, 3'h6, 5'd13);
		prog[3]  = i_word(12'hfff, 5'd0, 3'h4, 5'd14);
		prog[4]  = i_word(12'hfec, 5'd0, 3'h0, 5'd15);
		prog[5]  = r_word(7'h00, 5'd2, 5'd1, 3'h0, 5'd3);
		prog[6]  = r_word(7'h20, 5'd1, 5'd3, 3'h0, 5'd4);
		prog[7]  = i_word(12'hfff, 5'd4, 3'h4, 5'd5);
		prog[8]  = r_word(7'h00, 5'd2, 5'd5, 3'h6, 5'd6);
		prog[9]  = i_word(12'h0f0, 5'd6, 3'h7, 5'd7);
		prog[10] = r_word(7'h00, 5'd3, 5'd7, 3'h4, 5'd8);
		// load word, not an alu op
		prog[12] = 32'h0000_a083;
		prog[13] = r_word(7'h00, 5'd1, 5'd8, 3'h7, 5'd9);
		prog[14] = i_word(12'd1, 5'd1, 3'h0, 5'd1);
		prog[15] = i_word(12'hff8, 5'd9, 3'h6, 5'd10);
		// result to x0 is thrown away
		prog[16] = r_word(7'h00, 5'd2, 5'd1, 3'h0, 5'd0);
		prog[17] = i_word(12'd7, 5'd2, 3'h0, 5'd2);
		prog[20] = r_word(7'h00, 5'd4, 5'd10, 3'h0, 5'd11);
		// mul encoding, dropped by the dispatcher
		prog[22] = r_word(7'h01, 5'd2, 5'd1, 3'h0, 5'd13);
		prog[29] = r_word(7'h00, 5'd12, 5'd11, 3'h4, 5'd12);
	endtask

	task automatic load_cache();
		for (int i = 0; i < `ICACHE_LINES; i++) begin
			@(posedge clk);
			#1;
			fill_en = 1'b1;
			fill_index = line_idx_t'(i);
			fill_line = {prog[4*i+3], prog[4*i+2], prog[4*i+1], prog[4*i]};
		end
		@(posedge clk);
		#1;
		fill_en = 1'b0;
	endtask

	task automatic check_entry(input int_fifo_data_t e);
		inst_t w;
		addr_t exp_pc;
		data_t exp_b;
		cdb_t  res;
		logic  r;
		// new stream starts once the target shows up
		if (redirect_pending) begin
			if (e.pc == redirect_target) begin
				exp_idx = redirect_target[6:2];
				redirect_pending = 1'b0;
			end else begin
				// only entries already in the fifo may still drain
				old_pops++;
				assert (old_pops <= `INT_FIFO_DEPTH)
					else stop_with("the old stream kept going after the redirect");
			end
		end
		w = prog[e.pc[6:2]];
		r = (w[6:0] == R_TYPE);
		exp_pc = {25'd0, exp_idx, 2'b00};
		exp_b = r ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		assert (e.pc == exp_pc) else value_error("int_fifo_data.pc", e.pc, exp_pc);
		assert (e.opcode == w[6:0]) else value_error("int_fifo_data.opcode", e.opcode, w[6:0]);
		assert (e.func3 == w[14:12]) else value_error("int_fifo_data.func3", e.func3, w[14:12]);
		assert (e.func7 == w[31:25]) else value_error("int_fifo_data.func7", e.func7, w[31:25]);
		assert (e.rd == w[11:7]) else value_error("int_fifo_data.rd", e.rd, w[11:7]);
		assert (!pending[w[19:15]] && !(r && pending[w[24:20]]) && !pending[w[11:7]])
			else stop_with("an entry was popped while one of its registers was still pending");
		assert (e.common_data.rs1_data == model_regs[w[19:15]])
			else value_error("rs1_data", e.common_data.rs1_data, model_regs[w[19:15]]);
		assert (e.common_data.rs2_data == exp_b)
			else value_error("rs2_data", e.common_data.rs2_data, exp_b);
		res.tag = w[11:7];
		res.data = alu_result(w, model_regs[w[19:15]], exp_b);
		result_q.push_back(res);
		if (w[11:7] != '0) begin
			pending[w[11:7]] = 1'b1;
		end
		exp_idx = next_supported(exp_idx + 5'd1);
		pop_count++;
	endtask

	task automatic wait_pops(input int n);
		int target;
		int cycles;
		target = pop_count + n;
		cycles = 0;
		while (pop_count < target && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (pop_count < target) begin
			stop_with("timeout while waiting for entries from the integer fifo");
		end
	endtask

	// target far enough ahead that no queued entry carries its pc
	task automatic redirect_ahead();
		logic [4:0] t;
		int         cycles;
		@(posedge clk);
		#1;
		t = exp_idx;
		repeat (8) begin
			t = next_supported(t + 5'd1);
		end
		redirect_target = {25'd0, t, 2'b00};
		redirect_pending = 1'b1;
		old_pops = 0;
		jmp_branch_valid = 1'b1;
		jmp_branch_address = redirect_target;
		@(posedge clk);
		#1;
		jmp_branch_valid = 1'b0;
		cycles = 0;
		while (redirect_pending && cycles < 500) begin
			@(posedge clk);
			cycles++;
		end
		if (redirect_pending) begin
			stop_with("timeout while waiting for the redirect target to be popped");
		end
	endtask

	// integer unit model with random pop gaps and cdb delays
	always @(posedge clk) begin
		#1;
		int_rd = pop_enable && ($urandom_range(3) != 0);
		cdb_valid = 1'b0;
		if (result_q.size() > 0 && $urandom_range(2) != 0) begin
			cdb_valid = 1'b1;
			cdb = result_q.pop_front();
		end
	end

	always @(negedge clk) begin
		if (arst_n) begin
			assert (int_fifo_empty == (fifo_level == 0))
				else value_error("int_fifo_empty", int_fifo_empty, fifo_level == 0);
			assert (fifo_level <= `INT_FIFO_DEPTH)
				else stop_with("the integer fifo holds more entries than its depth");
			if (int_rd && !int_fifo_empty) begin
				check_entry(int_fifo_data);
				fifo_level--;
			end
			if (cdb_valid && cdb.tag != '0) begin
				model_regs[cdb.tag] = cdb.data;
				pending[cdb.tag] = 1'b0;
			end
			if (dut.dispatcher.issue) begin
				fifo_level++;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		!int_fifo_empty |-> !$isunknown(int_fifo_data))
		else stop_with("the head of the integer fifo has unknown bits");

	initial begin
		void'($urandom(32'h2c87_467c));
		arst_n = 1'b0;
		fill_en = 1'b0;
		fill_index = '0;
		fill_line = '0;
		jmp_branch_valid = 1'b0;
		jmp_branch_address = '0;
		cdb_valid = 1'b0;
		cdb = '0;
		int_rd = 1'b0;
		pop_enable = 1'b0;
		redirect_pending = 1'b0;
		redirect_target = '0;
		old_pops = 0;
		pop_count = 0;
		fifo_level = 0;
		pending = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		build_program();
		exp_idx = next_supported(5'd0);
		load_cache();
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// int_rd stays low so the fifo fills up
		repeat (30) @(posedge clk);
		assert (fifo_level == `INT_FIFO_DEPTH)
			else stop_with("the integer fifo did not fill up while int_rd was held low");
		pop_enable = 1'b1;
		wait_pops(40);
		redirect_ahead();
		wait_pops(12);
		redirect_ahead();
		wait_pops(20);
		$display("Regression passed");
		$finish;
	end

endmodule
